// File: list.f
src/voice_pkg.sv
src/user_controls.sv
src/noise_gate.sv
src/echo_effect.sv
src/output_stage.sv
src/voice_top.sv
verif/voice_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= voice_tb
RTL_TOP   ?= voice_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/voice_tb.sv
`timescale 1ns/100ps

module voice_tb import voice_pkg::*; ();

    localparam int delay_depth    = 16;
    localparam int gate_threshold = 256;
    localparam int gate_hold      = 8;
    localparam int wait_limit     = 32;  // cycles per wait loop
    localparam int sample_max     = 32767;
    localparam int sample_min     = -32768;

    logic       clk;
    logic       rst;
    logic [3:0] pbs;
    logic [1:0] vol;
    sample_s    sample_in;
    sample_s    sample_out;
    ctrl_s      ctrl;

    // reference model state
    sample_s                    exp_s1;   // after gate
    sample_s                    exp_s2;   // after echo
    sample_s                    exp_s3;   // after output stage
    int                         exp_cnt;  // quiet run length
    int                         exp_ptr;
    logic signed [sample_w-1:0] exp_line [delay_depth];

    logic [3:0] exp_bits;    // expected ptt and toggles indexed like pbs
    logic [3:0] exp_vol;
    enc_phase_t knob_ph;     // phase currently on the knob pins
    integer     seed;
    int         sent_count;
    int         out_count;
    int         data_errors;
    int         ctrl_errors;
    int         timeout_errors;

    voice_top #(
        .delay_depth    (delay_depth),
        .gate_threshold (gate_threshold),
        .gate_hold      (gate_hold)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .pbs        (pbs),
        .vol        (vol),
        .sample_in  (sample_in),
        .sample_out (sample_out),
        .ctrl       (ctrl)
    );

    always #2 clk = ~clk;  // 4 ns period

    // expected stream with one model stage per dut stage
    // ctrl is read at the top ports
    always @(posedge clk or posedge rst) begin
        int d;
        int mag;
        int cnt_next;
        int sum;
        int prod;
        if (rst) begin
            exp_s1  <= '0;
            exp_s2  <= '0;
            exp_s3  <= '0;
            exp_cnt <= 0;
            exp_ptr <= 0;
            for (int i = 0; i < delay_depth; i++)
                exp_line[i] <= '0;
        end else begin
            exp_s1.valid <= sample_in.valid;
            if (sample_in.valid) begin
                d   = int'(sample_in.data);
                mag = (d < 0) ? -d : d;
                if (mag >= gate_threshold)
                    cnt_next = 0;  // loud sample reopens
                else
                    cnt_next = (exp_cnt < gate_hold) ? exp_cnt + 1 : gate_hold;
                exp_cnt     <= cnt_next;
                exp_s1.data <= (ctrl.gate_en && cnt_next == gate_hold) ? '0 : sample_in.data;
            end
            exp_s2.valid <= exp_s1.valid;
            if (exp_s1.valid) begin
                d   = int'(exp_s1.data);
                sum = d + (int'(exp_line[exp_ptr]) >>> 1);  // half of the old sample
                if (sum > sample_max)
                    sum = sample_max;
                else if (sum < sample_min)
                    sum = sample_min;
                exp_s2.data       <= ctrl.effect_en ? sample_w'(sum) : exp_s1.data;
                exp_line[exp_ptr] <= exp_s1.data;
                exp_ptr           <= (exp_ptr + 1) % delay_depth;
            end
            exp_s3.valid <= exp_s2.valid;
            if (exp_s2.valid) begin
                prod = int'(exp_s2.data) * int'(ctrl.volume);
                if (ctrl.mute || !ctrl.ptt)
                    exp_s3.data <= '0;
                else
                    exp_s3.data <= sample_w'(prod >>> 4);  // volume/16
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && sample_out.valid)
            out_count++;
    end

    // stream checks sampled mid-cycle
    assert property (@(negedge clk) disable iff (rst) sample_out.valid == exp_s3.valid)
    else begin
        data_errors++;
        $display("mismatch sample_out.valid: got %h expected %h", sample_out.valid, exp_s3.valid);
    end

    assert property (@(negedge clk) disable iff (rst)
        exp_s3.valid |-> (sample_out.data == exp_s3.data))
    else begin
        data_errors++;
        $display("mismatch sample_out.data: got %h expected %h", sample_out.data, exp_s3.data);
    end

    function automatic logic ctrl_bit(input int b);
        case (b)
            pb_ptt:    return ctrl.ptt;
            pb_mute:   return ctrl.mute;
            pb_effect: return ctrl.effect_en;
            default:   return ctrl.gate_en;
        endcase
    endfunction

    function automatic string ctrl_name(input int b);
        case (b)
            pb_ptt:    return "ptt";
            pb_mute:   return "mute";
            pb_effect: return "effect_en";
            default:   return "gate_en";
        endcase
    endfunction

    task automatic check_bit(input int b);
        assert (ctrl_bit(b) == exp_bits[b])
        else begin
            ctrl_errors++;
            $display("mismatch ctrl.%s: got %h expected %h",
                     ctrl_name(b), ctrl_bit(b), exp_bits[b]);
        end
    endtask

    task automatic check_volume();
        assert (ctrl.volume == exp_vol)
        else begin
            ctrl_errors++;
            $display("mismatch ctrl.volume: got %h expected %h", ctrl.volume, exp_vol);
        end
    endtask

    task automatic wait_for_bit(input int b);
        int n;
        n = 0;
        @(negedge clk);
        while (ctrl_bit(b) != exp_bits[b] && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (ctrl_bit(b) != exp_bits[b]) begin
            timeout_errors++;
            $display("ctrl.%s did not change within %0d cycles", ctrl_name(b), wait_limit);
        end
    endtask

    task automatic wait_for_volume();
        int n;
        n = 0;
        @(negedge clk);
        while (ctrl.volume != exp_vol && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (ctrl.volume != exp_vol) begin
            timeout_errors++;
            $display("ctrl.volume did not reach %0d within %0d cycles", exp_vol, wait_limit);
        end
    endtask

    // press and hold a toggle button
    // its bit flips only once
    task automatic press_toggle(input int b, input int hold);
        exp_bits[b] = ~exp_bits[b];
        @(posedge clk);
        pbs[b] <= 1'b1;
        wait_for_bit(b);
        repeat (hold) @(negedge clk);
        check_bit(b);
        @(posedge clk);
        pbs[b] <= 1'b0;
        repeat (6) @(negedge clk);
        check_bit(b);  // release does nothing
    endtask

    task automatic set_ptt(input logic level);
        exp_bits[pb_ptt] = level;
        @(posedge clk);
        pbs[pb_ptt] <= level;
        wait_for_bit(pb_ptt);
    endtask

    task automatic turn_knob(input logic clockwise);
        enc_phase_t next_ph;
        if (clockwise) begin
            next_ph = knob_ph.next();
            if (exp_vol != 4'd15)
                exp_vol = exp_vol + 4'd1;
        end else begin
            next_ph = knob_ph.prev();
            if (exp_vol != 4'd0)
                exp_vol = exp_vol - 4'd1;
        end
        knob_ph = next_ph;
        @(posedge clk);
        vol <= next_ph;
        wait_for_volume();
        repeat (4) @(negedge clk);  // no late extra step and saturation holds
        check_volume();
    endtask

    // skip a phase so the direction is unknown and volume stays
    task automatic jump_knob();
        enc_phase_t next_ph;
        next_ph = knob_ph.next();
        next_ph = next_ph.next();
        knob_ph = next_ph;
        @(posedge clk);
        vol <= next_ph;
        repeat (6) @(negedge clk);
        check_volume();
    endtask

    task automatic set_volume(input logic [3:0] target);
        while (exp_vol < target)
            turn_knob(1'b1);
        while (exp_vol > target)
            turn_knob(1'b0);
    endtask

    task automatic send_sample(input logic signed [sample_w-1:0] value);
        @(posedge clk);
        sample_in <= '{valid: 1'b1, data: value};
        sent_count++;
    endtask

    task automatic send_idle();
        @(posedge clk);
        sample_in <= '{valid: 1'b0, data: '0};
    endtask

    // random data mostly back to back with the odd gap
    task automatic send_random(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            send_sample(r[15:0]);
            if (r[16] && r[17])
                send_idle();
        end
        send_idle();
    endtask

    // loud sample then a quiet run longer than gate_hold
    // then loud again and a short quiet run
    task automatic send_gate_burst();
        send_sample(16'sd1200);
        for (int i = 0; i < 12; i++)
            send_sample(sample_w'(i * 21 - 120));
        send_sample(-16'sd255);  // still quiet
        send_sample(16'sd256);   // just loud
        for (int i = 0; i < 4; i++)
            send_sample(sample_w'(30 - i * 20));
        send_sample(-16'sd900);
        send_idle();
    endtask

    // near full scale with both signs so the echo sum overflows
    task automatic send_loud(input int n);
        logic [31:0] r;
        int          v;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            v = 28000 + int'(r[11:0]);
            if (r[16])
                v = -v;
            send_sample(sample_w'(v));
        end
        send_idle();
    endtask

    task automatic drain();
        send_idle();
        repeat (4) @(negedge clk);  // three-stage latency
    endtask

    task automatic finish_run();
        $display("errors: data %0d, control %0d, timeouts %0d",
                 data_errors, ctrl_errors, timeout_errors);
        if (data_errors + ctrl_errors + timeout_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    initial begin
        #100000;
        timeout_errors++;
        $display("simulation did not finish within the time limit");
        finish_run();
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        pbs            = '0;
        vol            = enc_p0;
        sample_in      = '0;
        seed           = 79549;
        knob_ph        = enc_p0;
        exp_bits       = '0;
        exp_vol        = '0;
        sent_count     = 0;
        out_count      = 0;
        data_errors    = 0;
        ctrl_errors    = 0;
        timeout_errors = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        assert (ctrl == '0)
        else begin
            ctrl_errors++;
            $display("mismatch ctrl after reset: got %h expected %h", ctrl, 8'h00);
        end
        assert (!sample_out.valid)
        else begin
            data_errors++;
            $display("mismatch sample_out.valid after reset: got %h expected %h",
                     sample_out.valid, 1'b0);
        end

        // toggles with short and long holds
        press_toggle(pb_mute, 2);
        press_toggle(pb_mute, 20);
        press_toggle(pb_effect, 15);
        press_toggle(pb_effect, 3);
        press_toggle(pb_gate, 10);
        press_toggle(pb_gate, 1);
        set_ptt(1'b1);
        set_ptt(1'b0);

        // knob up to the top and past it and then down to zero
        for (int i = 0; i < 17; i++)
            turn_knob(1'b1);
        jump_knob();
        for (int i = 0; i < 17; i++)
            turn_knob(1'b0);
        set_volume(4'd6);
        jump_knob();

        // plain path with volume scaling and silencing
        set_volume(4'd10);
        set_ptt(1'b1);
        send_random(60);
        set_ptt(1'b0);
        send_random(20);
        set_ptt(1'b1);
        press_toggle(pb_mute, 2);
        send_random(20);
        press_toggle(pb_mute, 2);
        set_volume(4'd13);
        send_random(20);

        // gate on and then the same burst with the gate off
        press_toggle(pb_gate, 2);
        send_gate_burst();
        send_gate_burst();
        press_toggle(pb_gate, 2);
        send_gate_burst();

        // echo with saturation at full volume
        set_volume(4'd15);
        press_toggle(pb_effect, 2);
        send_loud(40);
        send_random(30);
        press_toggle(pb_effect, 2);
        send_loud(10);
        drain();

        assert (out_count == sent_count)
        else begin
            data_errors++;
            $display("mismatch output count: got %h expected %h", out_count, sent_count);
        end
        finish_run();
    end

endmodule

// File: src/voice_top.sv
`timescale 1ns/100ps

module voice_top import voice_pkg::*; #(
    parameter int delay_depth    = 16,
    parameter int gate_threshold = 256,
    parameter int gate_hold      = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] pbs,         // ptt, mute, effect, gate
    input  logic [1:0] vol,         // knob phases
    input  sample_s    sample_in,
    output sample_s    sample_out,
    output ctrl_s      ctrl
);

    sample_s gate_out;  // noise gate to echo
    sample_s echo_out;  // echo to output stage

    user_controls u_controls (
        .clk  (clk),
        .rst  (rst),
        .pbs  (pbs),
        .vol  (vol),
        .ctrl (ctrl)
    );

    // three registered stages, three cycles input to output
    noise_gate #(
        .gate_threshold (gate_threshold),
        .gate_hold      (gate_hold)
    ) u_gate (
        .clk        (clk),
        .rst        (rst),
        .sample_in  (sample_in),
        .gate_en    (ctrl.gate_en),
        .sample_out (gate_out)
    );

    echo_effect #(
        .delay_depth (delay_depth)
    ) u_echo (
        .clk        (clk),
        .rst        (rst),
        .sample_in  (gate_out),
        .effect_en  (ctrl.effect_en),
        .sample_out (echo_out)
    );

    output_stage u_out (
        .clk        (clk),
        .rst        (rst),
        .sample_in  (echo_out),
        .ctrl       (ctrl),
        .sample_out (sample_out)
    );

endmodule

// File: src/output_stage.sv
`timescale 1ns/100ps

module output_stage import voice_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  sample_s sample_in,
    input  ctrl_s   ctrl,
    output sample_s sample_out
);

    logic signed [sample_w+4:0] product;  // 16 x 5 signed
    logic signed [sample_w-1:0] scaled;
    logic                       silence;
    logic                       valid_q;
    logic signed [sample_w-1:0] data_q;

    always_comb begin
        // volume gets a zero sign bit so it multiplies as unsigned
        product = $signed(sample_in.data) * $signed({1'b0, ctrl.volume});
        scaled  = product[sample_w+3:4];  // >>> 4, never overflows at 15/16
        // only speak while push-to-talk is held
        silence = ctrl.mute || !ctrl.ptt;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= sample_in.valid;  // valid always forwarded
    end

    always_ff @(posedge clk) begin
        if (sample_in.valid)
            data_q <= silence ? '0 : scaled;
    end

    assign sample_out = '{valid: valid_q, data: data_q};

endmodule

// File: src/echo_effect.sv
`timescale 1ns/100ps

module echo_effect import voice_pkg::*; #(
    parameter int delay_depth = 16  // echo distance in samples, power of two
) (
    input  logic    clk,
    input  logic    rst,
    input  sample_s sample_in,
    input  logic    effect_en,
    output sample_s sample_out
);

    localparam int ptr_w = $clog2(delay_depth);

    localparam logic signed [sample_w-1:0] sample_max = {1'b0, {(sample_w-1){1'b1}}};
    localparam logic signed [sample_w-1:0] sample_min = {1'b1, {(sample_w-1){1'b0}}};

    logic signed [sample_w-1:0] delay_line [delay_depth]; // circular buffer
    logic [ptr_w-1:0]           wr_ptr;                   // wraps on its own
    logic signed [sample_w-1:0] in_data;
    logic signed [sample_w-1:0] old_sample;               // delay_depth valid samples ago
    logic signed [sample_w:0]   echo_sum;                 // one guard bit
    logic signed [sample_w-1:0] echo_data;
    logic                       valid_q;
    logic signed [sample_w-1:0] data_q;

    assign in_data    = sample_in.data;
    assign old_sample = delay_line[wr_ptr];  // slot about to be overwritten

    always_comb begin
        // operands are sign-extended to 17 bits before the add
        echo_sum = in_data + (old_sample >>> 1);
        case (echo_sum[sample_w:sample_w-1])
            2'b01:   echo_data = sample_max;  // positive overflow
            2'b10:   echo_data = sample_min;  // negative overflow
            default: echo_data = echo_sum[sample_w-1:0];
        endcase
    end

    // the line is written whether or not the effect is on
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            for (int i = 0; i < delay_depth; i++)
                delay_line[i] <= '0;
        end else if (sample_in.valid) begin
            delay_line[wr_ptr] <= in_data;
            wr_ptr             <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= sample_in.valid;
    end

    always_ff @(posedge clk) begin
        if (sample_in.valid)
            data_q <= effect_en ? echo_data : in_data;
    end

    assign sample_out = '{valid: valid_q, data: data_q};

endmodule

// File: src/noise_gate.sv
`timescale 1ns/100ps

module noise_gate import voice_pkg::*; #(
    parameter int gate_threshold = 256, // magnitude below this is quiet
    parameter int gate_hold      = 8    // quiet samples before the gate closes
) (
    input  logic    clk,
    input  logic    rst,
    input  sample_s sample_in,
    input  logic    gate_en,
    output sample_s sample_out
);

    localparam int cnt_w = $clog2(gate_hold + 1);

    logic [cnt_w-1:0]           quiet_cnt;      // consecutive quiet samples, saturating
    logic [cnt_w-1:0]           quiet_cnt_next;
    logic [sample_w:0]          in_ext;         // one extra bit so -32768 has a magnitude
    logic [sample_w:0]          magnitude;
    logic                       quiet;
    logic                       gated;          // zero this sample
    logic                       valid_q;
    logic signed [sample_w-1:0] data_q;

    always_comb begin
        in_ext    = {sample_in.data[sample_w-1], sample_in.data};
        magnitude = in_ext[sample_w] ? -in_ext : in_ext;
        quiet     = magnitude < (sample_w + 1)'(gate_threshold);

        // count including the current sample
        if (!quiet)
            quiet_cnt_next = '0;  // any loud sample reopens
        else if (quiet_cnt == cnt_w'(gate_hold))
            quiet_cnt_next = quiet_cnt;
        else
            quiet_cnt_next = quiet_cnt + 1'b1;

        gated = gate_en && (quiet_cnt_next == cnt_w'(gate_hold));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quiet_cnt <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= sample_in.valid;
            if (sample_in.valid)
                quiet_cnt <= quiet_cnt_next;  // only real samples count
        end
    end

    always_ff @(posedge clk) begin
        if (sample_in.valid)
            data_q <= gated ? '0 : sample_in.data;
    end

    assign sample_out = '{valid: valid_q, data: data_q};

endmodule

// File: src/user_controls.sv
`timescale 1ns/100ps

module user_controls import voice_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] pbs,  // buttons, taken as clean
    input  logic [1:0] vol,  // quadrature knob
    output ctrl_s      ctrl
);

    logic [3:0] pbs_meta;    // first sync flop
    logic [3:0] pbs_sync;    // second sync flop
    logic [3:0] pbs_prev;    // pbs_sync one cycle back, for edge detect
    logic [3:0] pbs_rise;    // one-cycle pulse per button press

    enc_phase_t vol_meta;    // newer knob phase
    enc_phase_t vol_sync;    // older knob phase

    logic       step_cw;     // decoded this cycle
    logic       step_acw;
    logic       cw_q;        // decoded step, applied next edge
    logic       acw_q;

    ctrl_s      ctrl_next;

    // clockwise neighbor of a knob phase
    function automatic enc_phase_t cw_of(input enc_phase_t p);
        enc_phase_t n;
        case (p)
            enc_p0:  n = enc_p1;
            enc_p1:  n = enc_p2;
            enc_p2:  n = enc_p3;
            default: n = enc_p0;
        endcase
        return n;
    endfunction

    // two-flop synchronizers for buttons and knob
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pbs_meta <= '0;
            pbs_sync <= '0;
            pbs_prev <= '0;
            vol_meta <= enc_p0;
            vol_sync <= enc_p0;
        end else begin
            pbs_meta <= pbs;
            pbs_sync <= pbs_meta;
            pbs_prev <= pbs_sync;
            vol_meta <= enc_phase_t'(vol);
            vol_sync <= vol_meta;
        end
    end

    assign pbs_rise = pbs_sync & ~pbs_prev;

    // direction from the two sync stages
    // a two-phase jump matches neither neighbor and is dropped
    assign step_cw  = (vol_meta == cw_of(vol_sync));
    assign step_acw = (vol_sync == cw_of(vol_meta));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cw_q  <= 1'b0;
            acw_q <= 1'b0;
        end else begin
            cw_q  <= step_cw;
            acw_q <= step_acw;
        end
    end

    always_comb begin
        ctrl_next     = ctrl;
        ctrl_next.ptt = pbs_sync[pb_ptt]; // level, not a toggle
        if (pbs_rise[pb_mute])
            ctrl_next.mute = ~ctrl.mute;
        if (pbs_rise[pb_effect])
            ctrl_next.effect_en = ~ctrl.effect_en;
        if (pbs_rise[pb_gate])
            ctrl_next.gate_en = ~ctrl.gate_en;

        // saturating volume, holds at both ends
        if (cw_q && (ctrl.volume < vol_max)) begin
            ctrl_next.volume = ctrl.volume + 4'd1;
        end else if (acw_q && (ctrl.volume != 4'd0)) begin
            ctrl_next.volume = ctrl.volume - 4'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ctrl <= '0;  // all off, volume 0
        else
            ctrl <= ctrl_next;
    end

endmodule

// File: src/voice_pkg.sv
package voice_pkg;

    // sample word width of the whole path
    localparam int sample_w = 16;

    // largest knob volume, volume 15 is 15/16 gain
    localparam logic [3:0] vol_max = 4'd15;

    // pushbutton bit positions in pbs
    localparam int pb_ptt    = 0; // push-to-talk, held level
    localparam int pb_mute   = 1; // mute toggle
    localparam int pb_effect = 2; // echo toggle
    localparam int pb_gate   = 3; // noise gate toggle

    // one sample on the stream, valid is a single-cycle strobe
    typedef struct packed {
        logic                       valid;
        logic signed [sample_w-1:0] data;
    } sample_s;

    // user control state, driven by user_controls
    typedef struct packed {
        logic       ptt;       // push-to-talk held
        logic       gate_en;   // noise gate on
        logic       effect_en; // echo on
        logic       mute;      // output muted
        logic [3:0] volume;    // 0 is silent
    } ctrl_s;

    // quadrature knob phases, listed in clockwise order
    // each neighbor differs in one bit (gray code)
    typedef enum logic [1:0] {
        enc_p0 = 2'b00,
        enc_p1 = 2'b01,
        enc_p2 = 2'b11,
        enc_p3 = 2'b10
    } enc_phase_t;

endpackage
